// File: hdl/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// Geometry of the emulated Microwire EEPROM
`define EE_ADDR_BITS 6
`define EE_WORD_BITS 16
`define EE_WORDS 64

// All 64 words must add up to this
`define EE_CHECKSUM_SUM 16'hBABA

// Station address
`define EE_MAC_OUI 24'hEC3F05
`define EE_MAC_NIC 24'h000001

// PCI identity
`define EE_SUB_PID 16'h6120
`define EE_SUB_VID 16'hFACE
`define EE_PID 16'hABCD
`define EE_VID 16'h8086

// Word indices inside the ROM
`define EE_IDX_SUB_PID 6'h0B
`define EE_IDX_SUB_VID 6'h0C
`define EE_IDX_PID 6'h0D
`define EE_IDX_VID 6'h0E
`define EE_IDX_CHECKSUM 6'h3F

`endif

// File: hdl/eeprom_pkg.sv
`default_nettype none

`include "eeprom_defines.svh"

package eeprom_pkg;

	typedef logic [`EE_WORD_BITS-1:0] ee_word_t;
	typedef logic [`EE_ADDR_BITS-1:0] ee_addr_t;

	// Two opcode bits that follow the start bit
	typedef enum logic [1:0] {
		MW_OP_EXT   = 2'b00,
		MW_OP_WRITE = 2'b01,
		MW_OP_READ  = 2'b10,
		MW_OP_ERASE = 2'b11
	} mw_opcode_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_OPCODE,
		ST_ADDR,
		ST_DATA,
		ST_DONE
	} mw_state_e;

endpackage

`default_nettype wire

// File: hdl/mw_sync.sv
`timescale 1ns/1ps
`default_nettype none

module mw_sync(
	input  wire  clk_i,
	input  wire  rst_i,
	input  wire  sk_i,
	input  wire  cs_i,
	input  wire  di_i,
	output logic sk_rise_o,
	output logic cs_o,
	output logic di_o
);

// Bit order in the sync vectors is {sk, cs, di}
logic [2:0] meta_q;
logic [2:0] sync_q;
logic sk_prev_q;

////////////////////////////////////////////////////////////
// Two-flop synchronizers plus SK history

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		meta_q <= '0;
		sync_q <= '0;
		sk_prev_q <= 1'b0;
	end else begin
		meta_q <= {sk_i, cs_i, di_i};
		sync_q <= meta_q;
		sk_prev_q <= sync_q[2];
	end
end

// One clk_i pulse per SK rising edge
assign sk_rise_o = sync_q[2] & ~sk_prev_q;
assign cs_o = sync_q[1];
assign di_o = sync_q[0];

endmodule

`default_nettype wire

// File: hdl/mw_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module mw_cmd_decoder(
	input  wire                 clk_i,
	input  wire                 rst_i,
	input  wire                 sk_rise_i,
	input  wire                 cs_i,
	input  wire                 di_i,
	output logic                rd_en_o,
	output eeprom_pkg::ee_addr_t rd_addr_o,
	output logic                shift_o,
	output logic                drive_en_o
);

import eeprom_pkg::*;

// Counter must reach the word width for the trailing edge
localparam int CNT_BITS = $clog2(`EE_WORD_BITS + 1);
localparam logic [CNT_BITS-1:0] OP_LAST = CNT_BITS'(1);
localparam logic [CNT_BITS-1:0] ADDR_LAST = CNT_BITS'(`EE_ADDR_BITS - 1);
localparam logic [CNT_BITS-1:0] DATA_END = CNT_BITS'(`EE_WORD_BITS);

mw_state_e state;
mw_opcode_e opcode_q;
ee_addr_t addr_q;
logic [CNT_BITS-1:0] bit_cnt;

assign rd_addr_o = addr_q;

////////////////////////////////////////////////////////////
// Command FSM, advances on SK rising edges only

always_ff @(posedge clk_i) begin
	rd_en_o <= 1'b0;
	shift_o <= 1'b0;
	if (rst_i) begin
		state <= ST_IDLE;
		bit_cnt <= '0;
		drive_en_o <= 1'b0;
	end else if (!cs_i) begin
		// Deselect aborts whatever is in flight
		state <= ST_IDLE;
		bit_cnt <= '0;
		drive_en_o <= 1'b0;
	end else if (sk_rise_i) begin
		case (state)
		ST_IDLE: begin
			// Leading zeros are skipped until the start bit
			if (di_i) begin
				state <= ST_OPCODE;
				bit_cnt <= '0;
			end
		end
		ST_OPCODE: begin
			opcode_q <= mw_opcode_e'({opcode_q[0], di_i});
			if (bit_cnt == OP_LAST) begin
				state <= ST_ADDR;
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
		ST_ADDR: begin
			addr_q <= ee_addr_t'({addr_q[`EE_ADDR_BITS-2:0], di_i});
			if (bit_cnt == ADDR_LAST) begin
				bit_cnt <= '0;
				if (opcode_q == MW_OP_READ) begin
					rd_en_o <= 1'b1;
					drive_en_o <= 1'b1;
					state <= ST_DATA;
				end else begin
					state <= ST_DONE;
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
		ST_DATA: begin
			// 16 shifts, then the next edge ends the transfer
			if (bit_cnt == DATA_END) begin
				state <= ST_DONE;
				drive_en_o <= 1'b0;
			end else begin
				shift_o <= 1'b1;
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
		ST_DONE: begin
			// Wait here for CS to drop
			state <= ST_DONE;
		end
		default: begin
			state <= ST_IDLE;
		end
		endcase
	end
end

endmodule

`default_nettype wire

// File: hdl/config_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module config_rom #(
	parameter logic [23:0] MAC_OUI = `EE_MAC_OUI,
	parameter logic [23:0] MAC_NIC = `EE_MAC_NIC,
	parameter logic [15:0] SUB_PID = `EE_SUB_PID,
	parameter logic [15:0] SUB_VID = `EE_SUB_VID,
	parameter logic [15:0] PID = `EE_PID,
	parameter logic [15:0] VID = `EE_VID
)(
	input  wire                  clk_i,
	input  wire                  rst_i,
	input  wire                  rd_en_i,
	input  eeprom_pkg::ee_addr_t rd_addr_i,
	output logic                 rd_valid_o,
	output eeprom_pkg::ee_word_t rd_data_o
);

import eeprom_pkg::*;

////////////////////////////////////////////////////////////
// ROM contents

// Every word except the checksum
function automatic ee_word_t base_word(input ee_addr_t idx);
	case (idx)
	6'h00: return {MAC_OUI[15:8], MAC_OUI[23:16]};
	6'h01: return {MAC_NIC[23:16], MAC_OUI[7:0]};
	6'h02: return {MAC_NIC[7:0], MAC_NIC[15:8]};
	`EE_IDX_SUB_PID: return SUB_PID;
	`EE_IDX_SUB_VID: return SUB_VID;
	`EE_IDX_PID: return PID;
	`EE_IDX_VID: return VID;
	default: return '0;
	endcase
endfunction

// Last word balances the sum to the target, mod 2^16
function automatic ee_word_t checksum_word();
	ee_word_t sum;
	sum = '0;
	for (int i = 0; i < `EE_WORDS - 1; i++) begin
		sum = sum + base_word(ee_addr_t'(i));
	end
	return `EE_CHECKSUM_SUM - sum;
endfunction

localparam ee_word_t CHECKSUM = checksum_word();

ee_word_t rom [`EE_WORDS];

for (genvar i = 0; i < `EE_WORDS; i++) begin : g_rom
	localparam ee_word_t ENTRY =
		(i == `EE_IDX_CHECKSUM) ? CHECKSUM : base_word(ee_addr_t'(i));
	assign rom[i] = ENTRY;
end

////////////////////////////////////////////////////////////
// Registered read port

always_ff @(posedge clk_i) begin
	if (rst_i)
		rd_valid_o <= 1'b0;
	else
		rd_valid_o <= rd_en_i;
end

always_ff @(posedge clk_i) begin
	if (rd_en_i)
		rd_data_o <= rom[rd_addr_i];
end

endmodule

`default_nettype wire

// File: hdl/mw_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module mw_serializer(
	input  wire                  clk_i,
	input  wire                  rst_i,
	input  wire                  rd_valid_i,
	input  eeprom_pkg::ee_word_t rd_data_i,
	input  wire                  shift_i,
	input  wire                  drive_en_i,
	output logic                 do_o,
	output logic                 do_oe_o
);

import eeprom_pkg::*;

localparam int W = $bits(ee_word_t);

// Dummy bit on top of the data word
logic [W:0] sreg;

always_ff @(posedge clk_i) begin
	if (rst_i || !drive_en_i)
		sreg <= '0;
	else if (rd_valid_i)
		sreg <= {1'b0, rd_data_i};
	else if (shift_i)
		sreg <= {sreg[W-1:0], 1'b0};
end

always_ff @(posedge clk_i) begin
	if (rst_i)
		do_oe_o <= 1'b0;
	else
		do_oe_o <= drive_en_i;
end

// MSB first on the wire
assign do_o = sreg[W];

endmodule

`default_nettype wire

// File: hdl/eeprom_emu_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_emu_top(
	input  wire  clk_i,
	input  wire  rst_i,
	input  wire  sk_i,
	input  wire  cs_i,
	input  wire  di_i,
	output logic do_o,
	output logic do_oe_o
);

import eeprom_pkg::*;

logic sk_rise;
logic cs_sync;
logic di_sync;
logic rd_en;
ee_addr_t rd_addr;
logic shift;
logic drive_en;
logic rd_valid;
ee_word_t rd_data;

////////////////////////////////////////////////////////////
// Microwire front end

mw_sync sync_i(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.sk_i(sk_i),
	.cs_i(cs_i),
	.di_i(di_i),
	.sk_rise_o(sk_rise),
	.cs_o(cs_sync),
	.di_o(di_sync)
);

mw_cmd_decoder decoder_i(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.sk_rise_i(sk_rise),
	.cs_i(cs_sync),
	.di_i(di_sync),
	.rd_en_o(rd_en),
	.rd_addr_o(rd_addr),
	.shift_o(shift),
	.drive_en_o(drive_en)
);

////////////////////////////////////////////////////////////
// Contents and read-out

config_rom rom_i(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.rd_en_i(rd_en),
	.rd_addr_i(rd_addr),
	.rd_valid_o(rd_valid),
	.rd_data_o(rd_data)
);

mw_serializer serializer_i(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.rd_valid_i(rd_valid),
	.rd_data_i(rd_data),
	.shift_i(shift),
	.drive_en_i(drive_en),
	.do_o(do_o),
	.do_oe_o(do_oe_o)
);

endmodule

`default_nettype wire

// File: testbench/mw_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module mw_checker(
	input  wire                                clk_i,
	input  wire                                rst_i,
	input  wire                                sk_i,
	input  wire                                cs_i,
	input  wire                                di_i,
	input  wire                                do_i,
	input  wire                                do_oe_i,
	input  wire [`EE_WORDS*`EE_WORD_BITS-1:0] exp_words_i,
	output int                                 errors_o,
	output int                                 reads_o,
	output eeprom_pkg::ee_word_t               word_sum_o
);

import eeprom_pkg::*;

// clk_i cycles allowed from CS low to do_oe_o low
localparam int CS_OFF_LIMIT = 6;

mw_state_e state;
mw_opcode_e opcode;
ee_addr_t addr;
logic [`EE_WORD_BITS:0] bits;
logic seen [`EE_WORDS];
int bit_cnt;
int cs_low_cnt;
logic sk_q;
logic rst_q;

task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	$display("[FAIL] %s: got %0h expected %0h at %0t ns", name, got, exp, $time);
	errors_o = errors_o + 1;
endtask

task automatic finish_read();
	ee_word_t exp_word;
	exp_word = exp_words_i[addr*`EE_WORD_BITS +: `EE_WORD_BITS];
	if (bits[`EE_WORD_BITS] !== 1'b0)
		report_value("do_o dummy bit", 32'(bits[`EE_WORD_BITS]), 32'h0);
	if (bits[`EE_WORD_BITS-1:0] !== exp_word)
		report_value($sformatf("do_o word %0h", addr), 32'(bits[`EE_WORD_BITS-1:0]),
			32'(exp_word));
	reads_o = reads_o + 1;
	// Each address enters the sum once
	if (!seen[addr]) begin
		seen[addr] = 1'b1;
		word_sum_o = word_sum_o + bits[`EE_WORD_BITS-1:0];
	end
endtask

////////////////////////////////////////////////////////////
// One host sampling point just before an SK rise

task automatic sample_edge();
	logic exp_oe;
	exp_oe = (state == ST_DATA);
	if (do_oe_i !== exp_oe)
		report_value("do_oe_o", 32'(do_oe_i), 32'(exp_oe));
	if (!exp_oe && do_i !== 1'b0)
		report_value("do_o", 32'(do_i), 32'h0);
	case (state)
	ST_IDLE: begin
		if (di_i) begin
			state = ST_OPCODE;
			bit_cnt = 0;
		end
	end
	ST_OPCODE: begin
		opcode = mw_opcode_e'({opcode[0], di_i});
		bit_cnt = bit_cnt + 1;
		if (bit_cnt == 2) begin
			state = ST_ADDR;
			bit_cnt = 0;
		end
	end
	ST_ADDR: begin
		addr = {addr[`EE_ADDR_BITS-2:0], di_i};
		bit_cnt = bit_cnt + 1;
		if (bit_cnt == `EE_ADDR_BITS) begin
			bit_cnt = 0;
			if (opcode == MW_OP_READ)
				state = ST_DATA;
			else
				state = ST_DONE;
		end
	end
	ST_DATA: begin
		bits = {bits[`EE_WORD_BITS-1:0], do_i};
		bit_cnt = bit_cnt + 1;
		if (bit_cnt == `EE_WORD_BITS + 1) begin
			finish_read();
			state = ST_DONE;
		end
	end
	default: begin
	end
	endcase
endtask

always @(posedge clk_i) begin
	if (rst_i) begin
		state = ST_IDLE;
		bit_cnt = 0;
		cs_low_cnt = 0;
		errors_o = 0;
		reads_o = 0;
		word_sum_o = '0;
		for (int i = 0; i < `EE_WORDS; i++)
			seen[i] = 1'b0;
	end else begin
		// Outputs come out of reset quiet
		if (rst_q) begin
			if (do_oe_i !== 1'b0)
				report_value("do_oe_o after reset", 32'(do_oe_i), 32'h0);
			if (do_i !== 1'b0)
				report_value("do_o after reset", 32'(do_i), 32'h0);
		end
		if (!cs_i) begin
			if (cs_low_cnt == CS_OFF_LIMIT && do_oe_i !== 1'b0)
				report_value("do_oe_o after CS low", 32'(do_oe_i), 32'h0);
			cs_low_cnt = cs_low_cnt + 1;
			state = ST_IDLE;
			bit_cnt = 0;
		end else begin
			cs_low_cnt = 0;
			if (sk_i && !sk_q)
				sample_edge();
		end
	end
	sk_q = sk_i;
	rst_q = rst_i;
end

endmodule

`default_nettype wire

// File: testbench/tb_eeprom_emu.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module tb_eeprom_emu;

import eeprom_pkg::*;

localparam int SK_HALF_CYCLES = 8;
localparam int SK_PERIOD_NS = 2 * SK_HALF_CYCLES * 40;
localparam int N_RANDOM = 8;
localparam int NUM_READS = 3 + 4 + N_RANDOM + `EE_WORDS + 3 + 2;
// Reads plus three silent commands and two aborted reads
localparam int NUM_TXN = NUM_READS + 3 + 2;
// Worst case of 29 SK edges and one SK period deselected
localparam longint WATCHDOG_NS = longint'(NUM_TXN) * 30 * SK_PERIOD_NS + 100 * SK_PERIOD_NS;

logic clk_i = 1'b0;
logic rst_i;
logic sk_i;
logic cs_i;
logic di_i;
wire do_o;
wire do_oe_o;
wire [`EE_WORDS*`EE_WORD_BITS-1:0] exp_words;
int chk_errors;
int reads_checked;
ee_word_t word_sum;
int tb_errors;

always #20 clk_i = ~clk_i;

////////////////////////////////////////////////////////////
// Reference model of the EEPROM image

function automatic ee_word_t expected_word(input ee_addr_t a);
	logic [47:0] station;
	logic [7:0] mac [6];
	ee_word_t total;
	station = {`EE_MAC_OUI, `EE_MAC_NIC};
	// mac[0] is the first byte of the station address
	for (int n = 0; n < 6; n++) begin
		mac[n] = station[47-8*n -: 8];
	end
	if (a < 3)
		return {mac[2*a+1], mac[2*a]};
	case (a)
	`EE_IDX_SUB_PID: return `EE_SUB_PID;
	`EE_IDX_SUB_VID: return `EE_SUB_VID;
	`EE_IDX_PID: return `EE_PID;
	`EE_IDX_VID: return `EE_VID;
	`EE_IDX_CHECKSUM: begin
		total = `EE_SUB_PID + `EE_SUB_VID + `EE_PID + `EE_VID;
		for (int w = 0; w < 3; w++) begin
			total = total + {mac[2*w+1], mac[2*w]};
		end
		return `EE_CHECKSUM_SUM - total;
	end
	default: return '0;
	endcase
endfunction

for (genvar g = 0; g < `EE_WORDS; g++) begin : g_exp
	assign exp_words[g*`EE_WORD_BITS +: `EE_WORD_BITS] = expected_word(ee_addr_t'(g));
end

eeprom_emu_top UUT(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.sk_i(sk_i),
	.cs_i(cs_i),
	.di_i(di_i),
	.do_o(do_o),
	.do_oe_o(do_oe_o)
);

mw_checker checker_i(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.sk_i(sk_i),
	.cs_i(cs_i),
	.di_i(di_i),
	.do_i(do_o),
	.do_oe_i(do_oe_o),
	.exp_words_i(exp_words),
	.errors_o(chk_errors),
	.reads_o(reads_checked),
	.word_sum_o(word_sum)
);

////////////////////////////////////////////////////////////
// Microwire host

task automatic clock_bit(input logic b);
	sk_i <= 1'b0;
	di_i <= b;
	repeat (SK_HALF_CYCLES) @(posedge clk_i);
	sk_i <= 1'b1;
	repeat (SK_HALF_CYCLES) @(posedge clk_i);
endtask

task automatic deselect();
	cs_i <= 1'b0;
	sk_i <= 1'b0;
	di_i <= 1'b0;
	repeat (2 * SK_HALF_CYCLES) @(posedge clk_i);
endtask

task automatic send_command(input mw_opcode_e op, input ee_addr_t a, input int zeros,
		input int tail_edges);
	cs_i <= 1'b1;
	repeat (zeros) clock_bit(1'b0);
	clock_bit(1'b1);
	clock_bit(op[1]);
	clock_bit(op[0]);
	for (int i = `EE_ADDR_BITS - 1; i >= 0; i--) begin
		clock_bit(a[i]);
	end
	repeat (tail_edges) clock_bit(1'b0);
	deselect();
endtask

// Dummy bit, 16 data bits, one more edge to see do_oe_o drop
task automatic read_word(input ee_addr_t a, input int zeros);
	send_command(MW_OP_READ, a, zeros, `EE_WORD_BITS + 2);
endtask

function automatic ee_addr_t random_blank_addr();
	ee_addr_t a;
	a = ee_addr_t'($urandom % `EE_IDX_CHECKSUM);
	while (a < 3 || (a >= `EE_IDX_SUB_PID && a <= `EE_IDX_VID)) begin
		a = ee_addr_t'($urandom % `EE_IDX_CHECKSUM);
	end
	return a;
endfunction

initial begin
	void'($urandom(32'h9bb5));
	rst_i = 1'b1;
	sk_i = 1'b0;
	cs_i = 1'b0;
	di_i = 1'b0;
	tb_errors = 0;
	repeat (4) @(posedge clk_i);
	rst_i <= 1'b0;
	repeat (2 * SK_HALF_CYCLES) @(posedge clk_i);

	// MAC words
	read_word(6'h00, 0);
	read_word(6'h01, 2);
	read_word(6'h02, 1);

	// IDs, then blank words
	read_word(`EE_IDX_SUB_PID, 0);
	read_word(`EE_IDX_SUB_VID, 0);
	read_word(`EE_IDX_PID, 0);
	read_word(`EE_IDX_VID, 0);
	for (int n = 0; n < N_RANDOM; n++) begin
		read_word(random_blank_addr(), 0);
	end

	for (int n = 0; n < `EE_WORDS; n++) begin
		read_word(ee_addr_t'(n), 0);
	end

	// Commands with no data phase
	send_command(MW_OP_WRITE, 6'h01, 0, `EE_WORD_BITS + 1);
	read_word(6'h01, 0);
	send_command(MW_OP_ERASE, `EE_IDX_PID, 1, `EE_WORD_BITS + 1);
	read_word(`EE_IDX_PID, 0);
	send_command(MW_OP_EXT, 6'h30, 0, `EE_WORD_BITS + 1);
	read_word(`EE_IDX_CHECKSUM, 0);

	// CS dropped mid-transfer
	send_command(MW_OP_READ, `EE_IDX_SUB_VID, 0, 5);
	read_word(`EE_IDX_SUB_VID, 0);
	send_command(MW_OP_READ, 6'h00, 0, 1);
	read_word(6'h00, 0);

	repeat (4) @(posedge clk_i);
	if (word_sum != `EE_CHECKSUM_SUM) begin
		$display("[FAIL] word_sum: got %0h expected %0h", word_sum, `EE_CHECKSUM_SUM);
		tb_errors = tb_errors + 1;
	end
	$display("Summary: %0d checker errors, %0d testbench errors, %0d reads checked",
		chk_errors, tb_errors, reads_checked);
	if (chk_errors == 0 && tb_errors == 0) begin
		$display("PASS: all tests");
	end else begin
		$display("FAIL: see errors above");
	end
	$finish;
end

initial begin
	#(WATCHDOG_NS);
	$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
	$display("FAIL: see errors above");
	$finish;
end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/mw_sync.sv
hdl/mw_cmd_decoder.sv
hdl/config_rom.sv
hdl/mw_serializer.sv
hdl/eeprom_emu_top.sv
testbench/mw_checker.sv
testbench/tb_eeprom_emu.sv

// File: Makefile
TOP := tb_eeprom_emu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "PASS: all tests" sim.log || { echo "Simulation failed"; exit 1; }

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module eeprom_emu_top

clean:
	rm -rf obj_dir sim.log
